/* hdl/id_pkg.sv */
`default_nettype none

package id_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int INST_W     = 32;

    // instruction field widths and positions
    localparam int OP_W      = 6;
    localparam int FUNCT_W   = 6;
    localparam int SHAMT_W   = 5;
    localparam int IMM_W     = 16;
    localparam int OP_LSB    = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;
    localparam int FUNCT_LSB = 0;

    localparam int ALUOP_W  = 8;
    localparam int ALUSEL_W = 3;

    localparam logic [REG_ADDR_W-1:0] NOP_REG = '0;

    typedef enum logic [OP_W-1:0] {
        SPECIAL = 6'b000000,
        ADDI    = 6'b001000,
        ADDIU   = 6'b001001,
        SLTI    = 6'b001010,
        SLTIU   = 6'b001011,
        ANDI    = 6'b001100,
        ORI     = 6'b001101,
        XORI    = 6'b001110,
        LUI     = 6'b001111,
        PREF    = 6'b110011
    } op_e;

    // SPECIAL function field
    typedef enum logic [FUNCT_W-1:0] {
        SLL  = 6'b000000,
        SRL  = 6'b000010,
        SRA  = 6'b000011,
        SLLV = 6'b000100,
        SRLV = 6'b000110,
        SRAV = 6'b000111,
        MOVZ = 6'b001010,
        MOVN = 6'b001011,
        SYNC = 6'b001111,
        MFHI = 6'b010000,
        MTHI = 6'b010001,
        MFLO = 6'b010010,
        MTLO = 6'b010011,
        ADD  = 6'b100000,
        ADDU = 6'b100001,
        SUB  = 6'b100010,
        SUBU = 6'b100011,
        AND  = 6'b100100,
        OR   = 6'b100101,
        XOR  = 6'b100110,
        NOR  = 6'b100111,
        SLT  = 6'b101010,
        SLTU = 6'b101011
    } funct_e;

    typedef enum logic [ALUOP_W-1:0] {
        ALUOP_NOP   = 8'b00000000,
        ALUOP_SRL   = 8'b00000010,
        ALUOP_SRA   = 8'b00000011,
        ALUOP_SLLV  = 8'b00000100,
        ALUOP_SRLV  = 8'b00000110,
        ALUOP_SRAV  = 8'b00000111,
        ALUOP_MOVZ  = 8'b00001010,
        ALUOP_MOVN  = 8'b00001011,
        ALUOP_MFHI  = 8'b00010000,
        ALUOP_MTHI  = 8'b00010001,
        ALUOP_MFLO  = 8'b00010010,
        ALUOP_MTLO  = 8'b00010011,
        ALUOP_ADD   = 8'b00100000,
        ALUOP_ADDU  = 8'b00100001,
        ALUOP_SUB   = 8'b00100010,
        ALUOP_SUBU  = 8'b00100011,
        ALUOP_AND   = 8'b00100100,
        ALUOP_OR    = 8'b00100101,
        ALUOP_XOR   = 8'b00100110,
        ALUOP_NOR   = 8'b00100111,
        ALUOP_SLT   = 8'b00101010, // slti shares
        ALUOP_SLTU  = 8'b00101011, // sltiu shares
        ALUOP_ADDI  = 8'b01010101,
        ALUOP_ADDIU = 8'b01010110,
        ALUOP_ANDI  = 8'b01011001,
        ALUOP_ORI   = 8'b01011010,
        ALUOP_XORI  = 8'b01011011,
        ALUOP_LUI   = 8'b01011100,
        ALUOP_SLL   = 8'b01111100
    } aluop_e;

    typedef enum logic [ALUSEL_W-1:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100
    } alusel_e;

    typedef enum logic [1:0] {
        CMOVE_NONE = 2'b00,
        CMOVE_N    = 2'b01,
        CMOVE_Z    = 2'b10
    } cmove_e;

endpackage

`default_nettype wire

/* hdl/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  logic                          rst_n_i,
    input  logic [id_pkg::INST_W-1:0]     inst_i,
    input  logic [id_pkg::DATA_W-1:0]     rt_value_i,
    output logic                          reg1_read_o,
    output logic                          reg2_read_o,
    output logic [id_pkg::REG_ADDR_W-1:0] reg1_addr_o,
    output logic [id_pkg::REG_ADDR_W-1:0] reg2_addr_o,
    output logic [id_pkg::REG_ADDR_W-1:0] wd_o,
    output id_pkg::aluop_e                aluop_o,
    output id_pkg::alusel_e               alusel_o,
    output logic [id_pkg::DATA_W-1:0]     imm_o,
    output logic                          wreg_o,
    output logic                          illegal_o
);
    import id_pkg::*;

    op_e                   op;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [SHAMT_W-1:0]    sa;
    logic [IMM_W-1:0]      imm16;
    logic                  sa_form;
    logic                  wreg_base;
    logic                  valid;
    cmove_e                cmove;

    // SPECIAL function code to alu op
    function automatic aluop_e funct_aluop(funct_e f);
        case (f)
            AND:     return ALUOP_AND;
            OR:      return ALUOP_OR;
            XOR:     return ALUOP_XOR;
            NOR:     return ALUOP_NOR;
            SLL:     return ALUOP_SLL;
            SRL:     return ALUOP_SRL;
            SRA:     return ALUOP_SRA;
            SLLV:    return ALUOP_SLLV;
            SRLV:    return ALUOP_SRLV;
            SRAV:    return ALUOP_SRAV;
            MOVN:    return ALUOP_MOVN;
            MOVZ:    return ALUOP_MOVZ;
            MFHI:    return ALUOP_MFHI;
            MFLO:    return ALUOP_MFLO;
            MTHI:    return ALUOP_MTHI;
            MTLO:    return ALUOP_MTLO;
            ADD:     return ALUOP_ADD;
            ADDU:    return ALUOP_ADDU;
            SUB:     return ALUOP_SUB;
            SUBU:    return ALUOP_SUBU;
            SLT:     return ALUOP_SLT;
            SLTU:    return ALUOP_SLTU;
            default: return ALUOP_NOP; // sync
        endcase
    endfunction

    assign op      = op_e'(inst_i[OP_LSB +: OP_W]);
    assign funct   = funct_e'(inst_i[FUNCT_LSB +: FUNCT_W]);
    assign rs      = inst_i[RS_LSB +: REG_ADDR_W];
    assign rt      = inst_i[RT_LSB +: REG_ADDR_W];
    assign rd      = inst_i[RD_LSB +: REG_ADDR_W];
    assign sa      = inst_i[SHAMT_LSB +: SHAMT_W];
    assign imm16   = inst_i[IMM_W-1:0];
    assign sa_form = (inst_i[INST_W-1:RS_LSB] == '0); // op and rs both zero

    always_comb begin
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        reg1_addr_o = rs;
        reg2_addr_o = rt;
        wd_o        = rd;
        aluop_o     = ALUOP_NOP;
        alusel_o    = SEL_NOP;
        imm_o       = '0;
        wreg_base   = 1'b0;
        cmove       = CMOVE_NONE;
        valid       = 1'b0;

        if (!rst_n_i) begin
            reg1_addr_o = NOP_REG;
            reg2_addr_o = NOP_REG;
            wd_o        = NOP_REG;
            valid       = 1'b1; // no illegal flag in reset
        end else begin
            case (op)
                ANDI, ORI, XORI, LUI: begin
                    reg1_read_o = 1'b1;
                    wd_o        = rt;
                    wreg_base   = 1'b1;
                    valid       = 1'b1;
                    alusel_o    = SEL_LOGIC;
                    imm_o       = {{(DATA_W-IMM_W){1'b0}}, imm16};
                    case (op)
                        ANDI: aluop_o = ALUOP_ANDI;
                        ORI:  aluop_o = ALUOP_ORI;
                        XORI: aluop_o = ALUOP_XORI;
                        default: begin
                            aluop_o = ALUOP_LUI;
                            imm_o   = {imm16, {(DATA_W-IMM_W){1'b0}}}; // upper half
                        end
                    endcase
                end
                ADDI, ADDIU, SLTI, SLTIU: begin
                    reg1_read_o = 1'b1;
                    wd_o        = rt;
                    wreg_base   = 1'b1;
                    valid       = 1'b1;
                    alusel_o    = SEL_ARITH;
                    imm_o       = {{(DATA_W-IMM_W){imm16[IMM_W-1]}}, imm16};
                    case (op)
                        ADDI:    aluop_o = ALUOP_ADDI;
                        ADDIU:   aluop_o = ALUOP_ADDIU;
                        SLTI:    aluop_o = ALUOP_SLT;
                        default: aluop_o = ALUOP_SLTU;
                    endcase
                end
                PREF: begin
                    valid = 1'b1;
                end
                SPECIAL: begin
                    if (sa == '0) begin
                        aluop_o = funct_aluop(funct);
                        case (funct)
                            AND, OR, XOR, NOR: begin
                                reg1_read_o = 1'b1;
                                reg2_read_o = 1'b1;
                                wreg_base   = 1'b1;
                                valid       = 1'b1;
                                alusel_o    = SEL_LOGIC;
                            end
                            SLLV, SRLV, SRAV: begin
                                reg1_read_o = 1'b1;
                                reg2_read_o = 1'b1;
                                wreg_base   = 1'b1;
                                valid       = 1'b1;
                                alusel_o    = SEL_SHIFT;
                            end
                            ADD, ADDU, SUB, SUBU, SLT, SLTU: begin
                                reg1_read_o = 1'b1;
                                reg2_read_o = 1'b1;
                                wreg_base   = 1'b1;
                                valid       = 1'b1;
                                alusel_o    = SEL_ARITH;
                            end
                            MOVN, MOVZ: begin
                                reg1_read_o = 1'b1;
                                reg2_read_o = 1'b1;
                                valid       = 1'b1;
                                alusel_o    = SEL_MOVE;
                                cmove       = (funct == MOVN) ? CMOVE_N : CMOVE_Z;
                            end
                            MFHI, MFLO: begin
                                wreg_base = 1'b1;
                                valid     = 1'b1;
                                alusel_o  = SEL_MOVE;
                            end
                            MTHI, MTLO: begin
                                reg1_read_o = 1'b1; // hi/lo written in a later stage
                                valid       = 1'b1;
                            end
                            SYNC: begin
                                valid = 1'b1;
                            end
                            default: begin
                                valid = 1'b0;
                            end
                        endcase
                    end
                end
                default: begin
                    valid = 1'b0;
                end
            endcase

            // shift by amount overrides, op1 carries the shift count
            if (sa_form && (funct == SLL || funct == SRL || funct == SRA)) begin
                reg1_read_o = 1'b0;
                reg2_read_o = 1'b1;
                wd_o        = rd;
                wreg_base   = 1'b1;
                valid       = 1'b1;
                cmove       = CMOVE_NONE;
                alusel_o    = SEL_SHIFT;
                aluop_o     = funct_aluop(funct);
                imm_o       = {{(DATA_W-SHAMT_W){1'b0}}, sa};
            end
        end
    end

    // conditional moves look at the forwarded rt value
    always_comb begin
        case (cmove)
            CMOVE_N: wreg_o = |rt_value_i;
            CMOVE_Z: wreg_o = ~|rt_value_i;
            default: wreg_o = wreg_base;
        endcase
    end

    assign illegal_o = ~valid;

endmodule

`default_nettype wire

/* hdl/operand_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_mux (
    input  logic                          read_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] addr_i,
    input  logic [id_pkg::DATA_W-1:0]     rf_data_i,
    input  logic [id_pkg::DATA_W-1:0]     imm_i,
    input  logic                          ex_wreg_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] ex_wd_i,
    input  logic [id_pkg::DATA_W-1:0]     ex_wdata_i,
    input  logic                          mem_wreg_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] mem_wd_i,
    input  logic [id_pkg::DATA_W-1:0]     mem_wdata_i,
    output logic [id_pkg::DATA_W-1:0]     data_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_wreg_i && (ex_wd_i == addr_i);
    assign mem_hit = mem_wreg_i && (mem_wd_i == addr_i);

    // youngest result wins
    always_comb begin
        if (!read_i) begin
            data_o = imm_i;
        end else if (ex_hit) begin
            data_o = ex_wdata_i;
        end else if (mem_hit) begin
            data_o = mem_wdata_i;
        end else begin
            data_o = rf_data_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/id_ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  id_pkg::aluop_e                aluop_i,
    input  id_pkg::alusel_e               alusel_i,
    input  logic [id_pkg::DATA_W-1:0]     op1_i,
    input  logic [id_pkg::DATA_W-1:0]     op2_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] wd_i,
    input  logic                          wreg_i,
    input  logic                          illegal_i,
    output id_pkg::aluop_e                aluop_o,
    output id_pkg::alusel_e               alusel_o,
    output logic [id_pkg::DATA_W-1:0]     op1_o,
    output logic [id_pkg::DATA_W-1:0]     op2_o,
    output logic [id_pkg::REG_ADDR_W-1:0] wd_o,
    output logic                          wreg_o,
    output logic                          illegal_o
);
    import id_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            aluop_o   <= ALUOP_NOP;
            alusel_o  <= SEL_NOP;
            op1_o     <= '0;
            op2_o     <= '0;
            wd_o      <= NOP_REG;
            wreg_o    <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            aluop_o   <= aluop_i;
            alusel_o  <= alusel_i;
            op1_o     <= op1_i;
            op2_o     <= op2_i;
            wd_o      <= wd_i;
            wreg_o    <= wreg_i;
            illegal_o <= illegal_i;
        end
    end

    // an illegal word must never reach EX with a write
    a_no_write_when_illegal: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wreg_o |-> !illegal_o
    ) else $error("wreg_o set together with illegal_o");

    // reset leaves a bubble in EX
    a_reset_is_nop: assert property (
        @(posedge clk)
        !rst_n_i |=> (!wreg_o && aluop_o == ALUOP_NOP && alusel_o == SEL_NOP)
    ) else $error("ID/EX not a no-op after reset");

endmodule

`default_nettype wire

/* hdl/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [id_pkg::INST_W-1:0]     inst_i,
    input  logic [id_pkg::DATA_W-1:0]     reg1_data_i,
    input  logic [id_pkg::DATA_W-1:0]     reg2_data_i,
    input  logic                          ex_wreg_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] ex_wd_i,
    input  logic [id_pkg::DATA_W-1:0]     ex_wdata_i,
    input  logic                          mem_wreg_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] mem_wd_i,
    input  logic [id_pkg::DATA_W-1:0]     mem_wdata_i,
    output logic                          reg1_read_o,
    output logic [id_pkg::REG_ADDR_W-1:0] reg1_addr_o,
    output logic                          reg2_read_o,
    output logic [id_pkg::REG_ADDR_W-1:0] reg2_addr_o,
    output id_pkg::aluop_e                aluop_o,
    output id_pkg::alusel_e               alusel_o,
    output logic [id_pkg::DATA_W-1:0]     reg1_data_o,
    output logic [id_pkg::DATA_W-1:0]     reg2_data_o,
    output logic [id_pkg::REG_ADDR_W-1:0] wd_o,
    output logic                          wreg_o,
    output logic                          illegal_o
);
    import id_pkg::*;

    aluop_e                dec_aluop;
    alusel_e               dec_alusel;
    logic [REG_ADDR_W-1:0] dec_wd;
    logic                  dec_wreg;
    logic                  dec_illegal;
    logic [DATA_W-1:0]     imm;
    logic [DATA_W-1:0]     op1;
    logic [DATA_W-1:0]     op2;

    inst_decoder inst_decoder_inst (
        .rst_n_i     (rst_n_i),
        .inst_i      (inst_i),
        .rt_value_i  (op2),         // movn/movz condition
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o),
        .wd_o        (dec_wd),
        .aluop_o     (dec_aluop),
        .alusel_o    (dec_alusel),
        .imm_o       (imm),
        .wreg_o      (dec_wreg),
        .illegal_o   (dec_illegal)
    );

    operand_mux operand_mux_1_inst (
        .read_i      (reg1_read_o),
        .addr_i      (reg1_addr_o),
        .rf_data_i   (reg1_data_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .data_o      (op1)
    );

    operand_mux operand_mux_2_inst (
        .read_i      (reg2_read_o),
        .addr_i      (reg2_addr_o),
        .rf_data_i   (reg2_data_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .data_o      (op2)
    );

    id_ex_reg id_ex_reg_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .aluop_i   (dec_aluop),
        .alusel_i  (dec_alusel),
        .op1_i     (op1),
        .op2_i     (op2),
        .wd_i      (dec_wd),
        .wreg_i    (dec_wreg),
        .illegal_i (dec_illegal),
        .aluop_o   (aluop_o),
        .alusel_o  (alusel_o),
        .op1_o     (reg1_data_o),
        .op2_o     (reg2_data_o),
        .wd_o      (wd_o),
        .wreg_o    (wreg_o),
        .illegal_o (illegal_o)
    );

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o; // 20 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
    import id_pkg::*;

    localparam int N_MAP   = 9 + 23 + 32;
    localparam int N_IMM   = 80;
    localparam int N_FWD   = 200;
    localparam int N_CMOVE = 120;
    localparam int LIMIT   = 10 + N_MAP + N_IMM + N_FWD + N_CMOVE + 5 * 3 + 50;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst_i;
    logic [31:0] reg1_data_i;
    logic [31:0] reg2_data_i;
    logic        ex_wreg_i;
    logic [4:0]  ex_wd_i;
    logic [31:0] ex_wdata_i;
    logic        mem_wreg_i;
    logic [4:0]  mem_wd_i;
    logic [31:0] mem_wdata_i;
    logic        reg1_read_o;
    logic [4:0]  reg1_addr_o;
    logic        reg2_read_o;
    logic [4:0]  reg2_addr_o;
    aluop_e      aluop_o;
    alusel_e     alusel_o;
    logic [31:0] reg1_data_o;
    logic [31:0] reg2_data_o;
    logic [4:0]  wd_o;
    logic        wreg_o;
    logic        illegal_o;

    // model of the decode, then the ID/EX copy of it
    logic [7:0]  m_aluop;
    logic [2:0]  m_sel;
    logic [31:0] m_op1;
    logic [31:0] m_op2;
    logic [31:0] m_imm;
    logic [4:0]  m_wd;
    logic        m_wr;
    logic        m_legal;
    logic        m_r1;
    logic        m_r2;
    logic [1:0]  m_cm;
    logic [7:0]  exp_aluop;
    logic [2:0]  exp_sel;
    logic [31:0] exp_op1;
    logic [31:0] exp_op2;
    logic [4:0]  exp_wd;
    logic        exp_wr;
    logic        exp_illegal;
    logic        chk_en;
    logic [5:0]  f_op;
    logic [5:0]  f_fn;
    logic [4:0]  f_rs;
    logic [4:0]  f_rt;
    logic [4:0]  f_rd;
    logic [4:0]  f_sa;

    int          err_cnt = 0;
    int          fail_tests = 0;
    int          cyc = 0;
    logic [31:0] rnd_state = 32'h22d6_767c;

    logic [5:0] op_list [0:8] = '{ANDI, ORI, XORI, LUI, ADDI, ADDIU, SLTI, SLTIU, PREF};
    logic [5:0] fn_list [0:22] = '{AND, OR, XOR, NOR, SLL, SRL, SRA, SLLV, SRLV, SRAV, SYNC,
        MOVN, MOVZ, MFHI, MFLO, MTHI, MTLO, ADD, ADDU, SUB, SUBU, SLT, SLTU};

    tb_clk_gen tb_clk_gen_inst (.clk_o(clk), .rst_n_o(rst_n));

    id_stage id_stage_inst (
        .clk(clk), .rst_n_i(rst_n), .inst_i(inst_i),
        .reg1_data_i(reg1_data_i), .reg2_data_i(reg2_data_i),
        .ex_wreg_i(ex_wreg_i), .ex_wd_i(ex_wd_i), .ex_wdata_i(ex_wdata_i),
        .mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i), .mem_wdata_i(mem_wdata_i),
        .reg1_read_o(reg1_read_o), .reg1_addr_o(reg1_addr_o),
        .reg2_read_o(reg2_read_o), .reg2_addr_o(reg2_addr_o),
        .aluop_o(aluop_o), .alusel_o(alusel_o),
        .reg1_data_o(reg1_data_o), .reg2_data_o(reg2_data_o),
        .wd_o(wd_o), .wreg_o(wreg_o), .illegal_o(illegal_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] rf_value(input logic [4:0] a);
        return {27'd0, a} * 32'h0100_0081; // zero for r0
    endfunction

    function automatic logic [31:0] fwd_value(input logic [4:0] a);
        if (ex_wreg_i && ex_wd_i == a) return ex_wdata_i;
        if (mem_wreg_i && mem_wd_i == a) return mem_wdata_i;
        return rf_value(a);
    endfunction

    // ALU code table for SPECIAL function codes
    function automatic logic [7:0] aluop_for_funct(input logic [5:0] fn);
        case (fn)
            AND:     return ALUOP_AND;
            OR:      return ALUOP_OR;
            XOR:     return ALUOP_XOR;
            NOR:     return ALUOP_NOR;
            SLL:     return ALUOP_SLL;
            SRL:     return ALUOP_SRL;
            SRA:     return ALUOP_SRA;
            SLLV:    return ALUOP_SLLV;
            SRLV:    return ALUOP_SRLV;
            SRAV:    return ALUOP_SRAV;
            MOVN:    return ALUOP_MOVN;
            MOVZ:    return ALUOP_MOVZ;
            MFHI:    return ALUOP_MFHI;
            MFLO:    return ALUOP_MFLO;
            MTHI:    return ALUOP_MTHI;
            MTLO:    return ALUOP_MTLO;
            ADD:     return ALUOP_ADD;
            ADDU:    return ALUOP_ADDU;
            SUB:     return ALUOP_SUB;
            SUBU:    return ALUOP_SUBU;
            SLT:     return ALUOP_SLT;
            SLTU:    return ALUOP_SLTU;
            default: return ALUOP_NOP;
        endcase
    endfunction

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sa,
                                           input logic [5:0] fn);
        return {6'd0, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    assign reg1_data_i = rf_value(reg1_addr_o); // register file answers in the same cycle
    assign reg2_data_i = rf_value(reg2_addr_o);

    assign f_op = inst_i[31:26];
    assign f_rs = inst_i[25:21];
    assign f_rt = inst_i[20:16];
    assign f_rd = inst_i[15:11];
    assign f_sa = inst_i[10:6];
    assign f_fn = inst_i[5:0];

    always_comb begin
        m_r1 = 1'b0;
        m_r2 = 1'b0;
        m_wd = f_rd;
        m_aluop = ALUOP_NOP;
        m_sel = SEL_NOP;
        m_imm = '0;
        m_wr = 1'b0;
        m_legal = 1'b0;
        m_cm = 2'd0;
        case (f_op)
            ANDI, ORI, XORI, LUI: begin
                {m_r1, m_wr, m_legal, m_wd, m_sel} = {3'b111, f_rt, SEL_LOGIC};
                m_imm = (f_op == LUI) ? {inst_i[15:0], 16'h0} : {16'h0, inst_i[15:0]};
                m_aluop = (f_op == ANDI) ? ALUOP_ANDI : (f_op == ORI) ? ALUOP_ORI :
                          (f_op == XORI) ? ALUOP_XORI : ALUOP_LUI;
            end
            ADDI, ADDIU, SLTI, SLTIU: begin
                {m_r1, m_wr, m_legal, m_wd, m_sel} = {3'b111, f_rt, SEL_ARITH};
                m_imm = {{16{inst_i[15]}}, inst_i[15:0]}; // sign extended
                m_aluop = (f_op == ADDI) ? ALUOP_ADDI : (f_op == ADDIU) ? ALUOP_ADDIU :
                          (f_op == SLTI) ? ALUOP_SLT : ALUOP_SLTU;
            end
            PREF: m_legal = 1'b1;
            SPECIAL: begin
                if (f_sa == 5'd0) begin
                    m_aluop = aluop_for_funct(f_fn);
                    case (f_fn)
                        AND, OR, XOR, NOR:
                            {m_r1, m_r2, m_wr, m_legal, m_sel} = {4'hf, SEL_LOGIC};
                        SLLV, SRLV, SRAV:
                            {m_r1, m_r2, m_wr, m_legal, m_sel} = {4'hf, SEL_SHIFT};
                        ADD, ADDU, SUB, SUBU, SLT, SLTU:
                            {m_r1, m_r2, m_wr, m_legal, m_sel} = {4'hf, SEL_ARITH};
                        MOVN, MOVZ: begin
                            {m_r1, m_r2, m_legal, m_sel} = {3'b111, SEL_MOVE};
                            m_cm = (f_fn == MOVN) ? 2'd1 : 2'd2;
                        end
                        MFHI, MFLO: {m_wr, m_legal, m_sel} = {2'b11, SEL_MOVE};
                        MTHI, MTLO: {m_r1, m_legal} = 2'b11;
                        SYNC: m_legal = 1'b1;
                        default: m_legal = 1'b0;
                    endcase
                end
            end
            default: m_legal = 1'b0;
        endcase
        if (inst_i[31:21] == 11'd0 && (f_fn == SLL || f_fn == SRL || f_fn == SRA)) begin
            {m_r1, m_r2, m_wr, m_legal, m_sel} = {4'b0111, SEL_SHIFT};
            m_aluop = aluop_for_funct(f_fn);
            m_imm = {27'd0, f_sa};
        end
        m_op1 = m_r1 ? fwd_value(f_rs) : m_imm;
        m_op2 = m_r2 ? fwd_value(f_rt) : m_imm;
        if (m_cm == 2'd1) m_wr = (m_op2 != 32'd0);
        if (m_cm == 2'd2) m_wr = (m_op2 == 32'd0);
    end

    always_ff @(posedge clk) begin
        chk_en      <= 1'b1;
        exp_aluop   <= rst_n ? m_aluop : ALUOP_NOP;
        exp_sel     <= rst_n ? m_sel : SEL_NOP;
        exp_op1     <= rst_n ? m_op1 : 32'd0;
        exp_op2     <= rst_n ? m_op2 : 32'd0;
        exp_wd      <= rst_n ? m_wd : NOP_REG;
        exp_wr      <= rst_n & m_wr;
        exp_illegal <= rst_n & ~m_legal;
    end

    task automatic report_error(input string msg);
        err_cnt++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    a_reset_reads: assert property (@(posedge clk) !rst_n |-> !reg1_read_o && !reg2_read_o)
        else report_error("read enable set in reset");
    // read port follows inst_i in the same cycle
    a_read_port: assert property (@(posedge clk) rst_n |->
            reg1_read_o == m_r1 && reg2_read_o == m_r2 &&
            reg1_addr_o == f_rs && reg2_addr_o == f_rt)
        else report_error($sformatf("read port %b/%0d %b/%0d, expected %b/%0d %b/%0d",
                                    $sampled(reg1_read_o), $sampled(reg1_addr_o),
                                    $sampled(reg2_read_o), $sampled(reg2_addr_o),
                                    $sampled(m_r1), $sampled(f_rs),
                                    $sampled(m_r2), $sampled(f_rt)));
    a_illegal: assert property (@(posedge clk) chk_en |-> illegal_o == exp_illegal)
        else report_error($sformatf("illegal_o %b, expected %b",
                                    $sampled(illegal_o), $sampled(exp_illegal)));
    a_wreg: assert property (@(posedge clk) chk_en |-> wreg_o == exp_wr)
        else report_error($sformatf("wreg_o %b, expected %b",
                                    $sampled(wreg_o), $sampled(exp_wr)));
    a_wd: assert property (@(posedge clk) chk_en |-> wd_o == exp_wd)
        else report_error($sformatf("wd_o %0d, expected %0d",
                                    $sampled(wd_o), $sampled(exp_wd)));
    a_alusel: assert property (@(posedge clk) chk_en |-> alusel_o == exp_sel)
        else report_error($sformatf("alusel_o %0d, expected %0d",
                                    $sampled(alusel_o), $sampled(exp_sel)));
    a_aluop: assert property (@(posedge clk) chk_en && !exp_illegal |-> aluop_o == exp_aluop)
        else report_error($sformatf("aluop_o %h, expected %h",
                                    $sampled(aluop_o), $sampled(exp_aluop)));
    a_op1: assert property (@(posedge clk) chk_en |-> reg1_data_o == exp_op1)
        else report_error($sformatf("reg1_data_o %h, expected %h",
                                    $sampled(reg1_data_o), $sampled(exp_op1)));
    a_op2: assert property (@(posedge clk) chk_en |-> reg2_data_o == exp_op2)
        else report_error($sformatf("reg2_data_o %h, expected %h",
                                    $sampled(reg2_data_o), $sampled(exp_op2)));

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic next_rand(output logic [31:0] r);
        rnd_state = xorshift32(rnd_state);
        r = rnd_state;
    endtask

    // one instruction per cycle, forwarding paths random when asked
    task automatic drive(input logic [31:0] inst, input logic fwd_on);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        next_rand(a);
        next_rand(b);
        next_rand(c);
        @(posedge clk);
        inst_i      <= inst;
        ex_wreg_i   <= fwd_on & a[0];
        ex_wd_i     <= {3'd0, a[2:1]}; // small space so addresses match often
        ex_wdata_i  <= a[3] ? 32'd0 : b;
        mem_wreg_i  <= fwd_on & a[4];
        mem_wd_i    <= {3'd0, a[6:5]};
        mem_wdata_i <= a[7] ? 32'd0 : c;
    endtask

    task automatic end_test(input string name, input int errs_before);
        repeat (3) @(posedge clk); // last word is compared on the second edge
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - errs_before);
            fail_tests++;
        end
    endtask

    initial begin
        logic [31:0] r;
        int          e;
        inst_i = r_type(5'd1, 5'd2, 5'd3, 5'd0, ADD);
        {ex_wreg_i, ex_wd_i, ex_wdata_i} = '0;
        {mem_wreg_i, mem_wd_i, mem_wdata_i} = '0;

        e = err_cnt;
        while (!rst_n) @(posedge clk);
        drive(32'd0, 1'b0);
        end_test("reset", e);

        e = err_cnt;
        foreach (op_list[i]) begin
            next_rand(r);
            drive(i_type(op_list[i], r[4:0], r[9:5], r[31:16]), 1'b0);
        end
        foreach (fn_list[i]) drive(r_type(5'd0, 5'd2, 5'd3, 5'd0, fn_list[i]), 1'b0);
        for (int i = 0; i < 32; i++) begin
            next_rand(r);
            if (i % 2 == 1) begin
                drive(r_type(r[4:0], r[9:5], r[14:10], 5'd1 | r[19:15], ADD), 1'b0);
            end else if (r[31:26] inside {SPECIAL, ANDI, ORI, XORI, LUI, ADDI, ADDIU,
                                          SLTI, SLTIU, PREF}) begin
                drive({6'b111111, r[25:0]}, 1'b0);
            end else begin
                drive(r, 1'b0);
            end
        end
        end_test("opcode map", e);

        e = err_cnt;
        for (int i = 0; i < N_IMM; i++) begin
            next_rand(r);
            if (r[31]) begin
                drive(i_type(op_list[r[2:0]], r[7:3], r[12:8], r[28:13]), 1'b0);
            end else begin
                drive(r_type(5'd0, r[4:0], r[9:5], r[14:10], fn_list[4 + r[16:15] % 3]),
                      1'b0);
            end
        end
        end_test("immediates", e);

        e = err_cnt;
        for (int i = 0; i < N_FWD; i++) begin
            next_rand(r);
            drive(r_type({3'd0, r[1:0]}, {3'd0, r[3:2]}, r[8:4], 5'd0,
                         fn_list[17 + r[10:9]]), 1'b1);
        end
        end_test("forwarding", e);

        e = err_cnt;
        for (int i = 0; i < N_CMOVE; i++) begin
            next_rand(r);
            drive(r_type({3'd0, r[1:0]}, {3'd0, r[3:2]}, r[8:4], 5'd0,
                         r[9] ? MOVN : MOVZ), 1'b1);
        end
        end_test("conditional move", e);

        $display("tests run 5, tests failed %0d, errors %0d", fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hdl/id_pkg.sv
hdl/inst_decoder.sv
hdl/operand_mux.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
sim/tb_clk_gen.sv
sim/tb_id_stage.sv

/* run.sh */
#!/bin/sh
# build and run the ID stage testbench with Verilator
verilator --binary --timing --assert -f flist.f --top-module tb_id_stage -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "^Testbench passed$" && exit 0 || exit 1
